// ==== design/switch_pkg.sv ====
package switch_pkg;

    // --------------------------------------------------
    // Switch geometry
    // --------------------------------------------------
    localparam int NUM_PORTS = 3;

    typedef logic [1:0]  port_idx_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [31:0] count_t;

    // One byte of a packet stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } axis_beat_t;

    // Decoded header of a buffered packet
    typedef struct packed {
        ip_addr_t dest_ip;
    } meta_t;

    typedef ip_addr_t [NUM_PORTS-1:0] ip_table_t;
    typedef count_t   [NUM_PORTS-1:0] count_vec_t;

    // --------------------------------------------------
    // AXI-Lite register block
    // --------------------------------------------------
    localparam int AXIL_ADDR_W = 6;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    typedef logic [AXIL_DATA_W-1:0] axil_data_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
        axil_data_t             data;
        logic [AXIL_STRB_W-1:0] strb;
    } axil_wr_t;

    // Word indices, one word per port from each base
    localparam int REG_IP_BASE   = 0;
    localparam int REG_RX_BASE   = 4;
    localparam int REG_DROP_BASE = 8;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // 192.168.1.10, .11 and .12 for ports 0, 1 and 2
    localparam ip_table_t RESET_IPS = {32'hc0a8_010c, 32'hc0a8_010b, 32'hc0a8_010a};

endpackage

// ==== design/sync_fifo.sv ====
module sync_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   not_empty,
    output logic   full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign head      = mem[rd_ptr];

    // Push into a full FIFO and pop from an empty one are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/port_ingress.sv ====
module port_ingress
    import switch_pkg::*;
#(
    parameter int DATA_DEPTH = 32,
    parameter int META_DEPTH = 4
) (
    input  logic       clk,
    input  logic       resetn,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    output axis_beat_t data_head,
    output logic       data_valid,
    input  logic       data_pop,
    output meta_t      meta_head,
    output logic       meta_valid,
    input  logic       meta_pop,
    output count_t     rx_count
);
    logic       data_full;
    logic       meta_full;
    logic       accept;
    logic       end_of_pkt;
    logic [2:0] byte_cnt;
    ip_addr_t   hdr_ip;
    ip_addr_t   next_ip;
    meta_t      meta_in;

    assign s_ready    = !data_full && !meta_full;
    assign accept     = s_valid && s_ready;
    assign end_of_pkt = accept && s_beat.last;

    // Header byte n lands in byte lane 3-n, so missing bytes stay zero
    always_comb
    begin
        next_ip = hdr_ip;
        if (byte_cnt < 3'd4)
            next_ip[(3 - int'(byte_cnt)) * 8 +: 8] = s_beat.data;
    end

    assign meta_in = '{dest_ip: next_ip};

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            byte_cnt <= '0;
            hdr_ip   <= '0;
            rx_count <= '0;
        end
        else if (end_of_pkt)
        begin
            byte_cnt <= '0;
            hdr_ip   <= '0;
            rx_count <= rx_count + 1'b1;
        end
        else if (accept)
        begin
            hdr_ip <= next_ip;
            if (byte_cnt < 3'd4)
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Packet bytes and decoded headers
    // --------------------------------------------------
    sync_fifo #(
        .entry_t (axis_beat_t),
        .DEPTH   (DATA_DEPTH)
    ) u_data_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (accept),
        .push_data (s_beat),
        .pop       (data_pop),
        .head      (data_head),
        .not_empty (data_valid),
        .full      (data_full)
    );

    sync_fifo #(
        .entry_t (meta_t),
        .DEPTH   (META_DEPTH)
    ) u_meta_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (end_of_pkt),
        .push_data (meta_in),
        .pop       (meta_pop),
        .head      (meta_head),
        .not_empty (meta_valid),
        .full      (meta_full)
    );

endmodule

// ==== design/switch_fabric.sv ====
module switch_fabric
    import switch_pkg::*;
(
    input  logic                       clk,
    input  logic                       resetn,
    input  axis_beat_t [NUM_PORTS-1:0] data_head,
    input  logic [NUM_PORTS-1:0]       data_valid,
    output logic [NUM_PORTS-1:0]       data_pop,
    input  meta_t [NUM_PORTS-1:0]      meta_head,
    input  logic [NUM_PORTS-1:0]       meta_valid,
    output logic [NUM_PORTS-1:0]       meta_pop,
    input  ip_table_t                  ip_table,
    output axis_beat_t [NUM_PORTS-1:0] m_beat,
    output logic [NUM_PORTS-1:0]       m_valid,
    input  logic [NUM_PORTS-1:0]       m_ready,
    output count_vec_t                 drop_counts
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_DRAIN
    } state_t;

    state_t     state;
    port_idx_t  rr_ptr;
    port_idx_t  src;
    port_idx_t  dst;
    port_idx_t  pick;
    logic       pick_valid;
    port_idx_t  match_idx;
    logic       match_hit;
    axis_beat_t src_beat;
    logic       src_valid;
    logic       src_pop;

    // --------------------------------------------------
    // Round-robin pick, starting after the last port served
    // --------------------------------------------------
    always_comb
    begin
        int idx;
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++)
        begin
            idx = (int'(rr_ptr) + k) % NUM_PORTS;
            if (!pick_valid && meta_valid[idx])
            begin
                pick       = port_idx_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    // Lowest matching port wins, so scan from the top down
    always_comb
    begin
        match_idx = '0;
        match_hit = 1'b0;
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (meta_head[pick].dest_ip == ip_table[i])
            begin
                match_idx = port_idx_t'(i);
                match_hit = 1'b1;
            end
        end
    end

    assign src_beat  = data_head[src];
    assign src_valid = data_valid[src];

    // --------------------------------------------------
    // Stream routing
    // --------------------------------------------------
    always_comb
    begin
        data_pop = '0;
        meta_pop = '0;
        m_beat   = '0;
        m_valid  = '0;
        src_pop  = 1'b0;
        case (state)
            ST_IDLE:
                meta_pop[pick] = pick_valid;
            ST_FORWARD:
            begin
                m_beat[dst]  = src_beat;
                m_valid[dst] = src_valid;
                src_pop      = src_valid && m_ready[dst];
            end
            // Discard one byte per cycle
            ST_DRAIN:
                src_pop = src_valid;
            default:
                src_pop = 1'b0;
        endcase
        data_pop[src] = src_pop;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state       <= ST_IDLE;
            rr_ptr      <= port_idx_t'(NUM_PORTS - 1);
            src         <= '0;
            dst         <= '0;
            drop_counts <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (pick_valid)
                    begin
                        src    <= pick;
                        dst    <= match_idx;
                        rr_ptr <= pick;
                        if (match_hit)
                            state <= ST_FORWARD;
                        else
                        begin
                            state             <= ST_DRAIN;
                            drop_counts[pick] <= drop_counts[pick] + 1'b1;
                        end
                    end
                ST_FORWARD, ST_DRAIN:
                    if (src_pop && src_beat.last)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/switch_regs.sv ====
module switch_regs
    import switch_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  axil_wr_t               wr,
    input  logic                   awvalid,
    input  logic                   wvalid,
    output logic                   awready,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [AXIL_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output axil_data_t             rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  count_vec_t             rx_counts,
    input  count_vec_t             drop_counts,
    output ip_table_t              ip_table
);
    localparam int WORD_W = AXIL_ADDR_W - 2;

    logic                   wr_idle;
    logic                   wr_start;
    logic [WORD_W-1:0]      wr_word;
    logic                   rd_start;
    logic [AXIL_ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0]      rd_word;
    axil_data_t             rd_mux;

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    // --------------------------------------------------
    // Write channel
    // --------------------------------------------------
    // Address and data are taken together, one write outstanding at most
    assign wr_start = awvalid && wvalid && wr_idle;
    assign wr_word  = wr.addr[AXIL_ADDR_W-1:2];

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            wr_idle <= 1'b1;
        end
        else
        begin
            awready <= wr_start;
            wready  <= wr_start;
            if (wr_start)
            begin
                bvalid  <= 1'b1;
                wr_idle <= 1'b0;
            end
            else if (bvalid && bready)
            begin
                bvalid  <= 1'b0;
                wr_idle <= 1'b1;
            end
        end
    end

    // Port IP table, byte-strobed
    always_ff @(posedge clk)
    begin
        if (!resetn)
            ip_table <= RESET_IPS;
        else if (wr_start)
        begin
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                if (int'(wr_word) == REG_IP_BASE + i)
                begin
                    for (int b = 0; b < AXIL_STRB_W; b++)
                    begin
                        if (wr.strb[b])
                            ip_table[i][b*8 +: 8] <= wr.data[b*8 +: 8];
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // Read channel
    // --------------------------------------------------
    assign rd_start = arvalid && !arready && !rvalid;
    assign rd_word  = rd_addr[AXIL_ADDR_W-1:2];

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            arready <= rd_start;
            if (arready && arvalid)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_start)
            rd_addr <= araddr;
        if (arready && arvalid)
            rdata <= rd_mux;
    end

    // Unmapped words read zero
    always_comb
    begin
        rd_mux = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (int'(rd_word) == REG_IP_BASE + i)
                rd_mux = ip_table[i];
            if (int'(rd_word) == REG_RX_BASE + i)
                rd_mux = rx_counts[i];
            if (int'(rd_word) == REG_DROP_BASE + i)
                rd_mux = drop_counts[i];
        end
    end

endmodule

// ==== design/packet_switch_top.sv ====
module packet_switch_top
    import switch_pkg::*;
#(
    parameter int DATA_DEPTH = 32,
    parameter int META_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  axis_beat_t [NUM_PORTS-1:0] s_beat,
    input  logic [NUM_PORTS-1:0]       s_valid,
    output logic [NUM_PORTS-1:0]       s_ready,
    output axis_beat_t [NUM_PORTS-1:0] m_beat,
    output logic [NUM_PORTS-1:0]       m_valid,
    input  logic [NUM_PORTS-1:0]       m_ready,
    input  axil_wr_t                   wr,
    input  logic                       awvalid,
    input  logic                       wvalid,
    output logic                       awready,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [AXIL_ADDR_W-1:0]     araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output axil_data_t                 rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    axis_beat_t [NUM_PORTS-1:0] data_head;
    logic [NUM_PORTS-1:0]       data_valid;
    logic [NUM_PORTS-1:0]       data_pop;
    meta_t [NUM_PORTS-1:0]      meta_head;
    logic [NUM_PORTS-1:0]       meta_valid;
    logic [NUM_PORTS-1:0]       meta_pop;
    ip_table_t                  ip_table;
    count_vec_t                 rx_counts;
    count_vec_t                 drop_counts;

    // --------------------------------------------------
    // Input buffers, one per port
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        port_ingress #(
            .DATA_DEPTH (DATA_DEPTH),
            .META_DEPTH (META_DEPTH)
        ) u_ingress (
            .clk        (clk),
            .resetn     (resetn),
            .s_beat     (s_beat[i]),
            .s_valid    (s_valid[i]),
            .s_ready    (s_ready[i]),
            .data_head  (data_head[i]),
            .data_valid (data_valid[i]),
            .data_pop   (data_pop[i]),
            .meta_head  (meta_head[i]),
            .meta_valid (meta_valid[i]),
            .meta_pop   (meta_pop[i]),
            .rx_count   (rx_counts[i])
        );
    end

    switch_fabric u_fabric (
        .clk         (clk),
        .resetn      (resetn),
        .data_head   (data_head),
        .data_valid  (data_valid),
        .data_pop    (data_pop),
        .meta_head   (meta_head),
        .meta_valid  (meta_valid),
        .meta_pop    (meta_pop),
        .ip_table    (ip_table),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .drop_counts (drop_counts)
    );

    switch_regs u_regs (
        .clk         (clk),
        .resetn      (resetn),
        .wr          (wr),
        .awvalid     (awvalid),
        .wvalid      (wvalid),
        .awready     (awready),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .rx_counts   (rx_counts),
        .drop_counts (drop_counts),
        .ip_table    (ip_table)
    );

endmodule

// ==== tb/packet_switch_asserts.sv ====
module packet_switch_asserts
    import switch_pkg::*;
(
    input logic                       clk,
    input logic                       resetn,
    input axis_beat_t [NUM_PORTS-1:0] m_beat,
    input logic [NUM_PORTS-1:0]       m_valid,
    input logic [NUM_PORTS-1:0]       m_ready,
    input logic                       bvalid,
    input logic                       bready,
    input logic                       rvalid,
    input logic                       rready
);
    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_out
        // Output beat frozen while the sink stalls
        a_beat_stable: assert property (@(posedge clk) disable iff (!resetn)
            m_valid[i] && !m_ready[i] |=> m_valid[i] && $stable(m_beat[i]))
            else $error("output beat changed while stalled");

        // A packet keeps to one output, without gaps, until its last beat
        a_one_output: assert property (@(posedge clk) disable iff (!resetn)
            m_valid[i] && !(m_ready[i] && m_beat[i].last) |=> m_valid == NUM_PORTS'(1 << i))
            else $error("packet left its output before the last beat");
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind packet_switch_top packet_switch_asserts u_asserts (.*);

// ==== tb/packet_switch_tb.sv ====
module packet_switch_tb;
    import switch_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS   = 12;
    localparam int ROW_CYCLES = 40;
    localparam int REMAP_ROW  = 6;

    typedef struct {
        string    name;
        int       src;
        ip_addr_t ip;
        int       len;
        bit       stall;
        bit       par;
    } row_t;

    logic                       clk;
    logic                       resetn;
    axis_beat_t [NUM_PORTS-1:0] s_beat;
    logic [NUM_PORTS-1:0]       s_valid;
    logic [NUM_PORTS-1:0]       s_ready;
    axis_beat_t [NUM_PORTS-1:0] m_beat;
    logic [NUM_PORTS-1:0]       m_valid;
    logic [NUM_PORTS-1:0]       m_ready;
    axil_wr_t                   wr;
    logic                       awvalid;
    logic                       wvalid;
    logic                       awready;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;
    logic [AXIL_ADDR_W-1:0]     araddr;
    logic                       arvalid;
    logic                       arready;
    axil_data_t                 rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;

    row_t       rows [NUM_ROWS];
    ip_table_t  ip_model;
    count_vec_t rx_exp;
    count_vec_t drop_exp;
    axis_beat_t tx_q [NUM_PORTS][$];
    axis_beat_t exp_q [NUM_PORTS][$];
    string      name_q [NUM_PORTS][$];
    bit         stall_en;

    packet_switch_top #(
        .DATA_DEPTH (32),
        .META_DEPTH (4)
    ) uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial
    begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD + 300 * CLK_PERIOD);
        $display("Timeout: the switch did not finish its traffic in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string name, input axil_data_t exp, input axil_data_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------
    // Bus tasks
    // --------------------------------------------------
    task automatic axil_write(input int word, input axil_data_t data, input logic [3:0] strb);
        @(negedge clk);
        wr      = '{addr: AXIL_ADDR_W'(word * 4), data: data, strb: strb};
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do
            @(negedge clk);
        while (!(awready && wready));
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            @(negedge clk);
        check_reg("write response", axil_data_t'(RESP_OKAY), axil_data_t'(bresp));
        // Response held back for one cycle before it is taken
        @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input int word, output axil_data_t data);
        @(negedge clk);
        araddr  = AXIL_ADDR_W'(word * 4);
        arvalid = 1'b1;
        do
            @(negedge clk);
        while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clk);
        data = rdata;
        check_reg("read response", axil_data_t'(RESP_OKAY), axil_data_t'(rresp));
        // Response held back for one cycle before it is taken
        @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic read_check(input string name, input int word, input axil_data_t exp);
        axil_data_t val;
        axil_read(word, val);
        check_reg(name, exp, val);
    endtask

    // --------------------------------------------------
    // Reference model and stimulus
    // --------------------------------------------------
    function automatic int route_port(input ip_addr_t ip);
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (ip == ip_model[i])
                return i;
        end
        return -1;
    endfunction

    task automatic set_row(input int i, input string name, input int src, input ip_addr_t ip,
                           input int len, input bit stall, input bit par);
        rows[i] = '{name: name, src: src, ip: ip, len: len, stall: stall, par: par};
    endtask

    task automatic load_table();
        set_row(0,  "p0_to_p0",    0, 32'hc0a8_010a, 8,  1'b0, 1'b0);
        set_row(1,  "p0_to_p1",    0, 32'hc0a8_010b, 5,  1'b0, 1'b0);
        set_row(2,  "p1_to_p2",    1, 32'hc0a8_010c, 16, 1'b0, 1'b0);
        set_row(3,  "p2_to_p0",    2, 32'hc0a8_010a, 4,  1'b0, 1'b0);
        set_row(4,  "unknown_ip",  1, 32'h0a00_0001, 6,  1'b0, 1'b0);
        set_row(5,  "stall_p2_p1", 2, 32'hc0a8_010b, 12, 1'b1, 1'b0);
        set_row(6,  "old_ip_drop", 0, 32'hc0a8_010b, 7,  1'b0, 1'b0);
        set_row(7,  "new_ip_p1",   2, 32'hc0a8_0120, 9,  1'b1, 1'b0);
        set_row(8,  "par_a",       0, 32'hc0a8_010a, 10, 1'b1, 1'b1);
        set_row(9,  "par_b",       1, 32'hc0a8_010c, 13, 1'b1, 1'b0);
        set_row(10, "par_c",       2, 32'hc0a8_0120, 8,  1'b1, 1'b1);
        set_row(11, "par_d",       0, 32'hc0a8_010c, 11, 1'b0, 1'b0);
    endtask

    // Header bytes first, most significant first, then random payload
    task automatic prepare_row(input int i);
        axis_beat_t b;
        int         dst;
        dst = route_port(rows[i].ip);
        for (int k = 0; k < rows[i].len; k++)
        begin
            if (k < 4)
                b.data = rows[i].ip[(3 - k) * 8 +: 8];
            else
                b.data = 8'($urandom_range(255, 0));
            b.last = (k == rows[i].len - 1);
            tx_q[rows[i].src].push_back(b);
            if (dst >= 0)
            begin
                exp_q[dst].push_back(b);
                name_q[dst].push_back(rows[i].name);
            end
        end
        rx_exp[rows[i].src] = rx_exp[rows[i].src] + 1;
        if (dst < 0)
            drop_exp[rows[i].src] = drop_exp[rows[i].src] + 1;
    endtask

    task automatic send_port(input int p);
        while (tx_q[p].size() > 0)
        begin
            @(negedge clk);
            s_beat[p]  = tx_q[p][0];
            s_valid[p] = 1'b1;
            if (s_ready[p])
                void'(tx_q[p].pop_front());
        end
        @(negedge clk);
        s_valid[p] = 1'b0;
    endtask

    // Outputs drained, then drop counters caught up with the model
    task automatic wait_idle();
        axil_data_t val;
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() > 0)
            @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            axil_read(REG_DROP_BASE + p, val);
            while (val != drop_exp[p])
                axil_read(REG_DROP_BASE + p, val);
        end
    endtask

    // Sink side: choose m_ready and check the beat taken at the next edge
    initial
    begin
        string      name;
        axis_beat_t exp;
        m_ready = '1;
        forever
        begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                m_ready[p] = stall_en ? ($urandom_range(3, 0) != 0) : 1'b1;
                if (resetn && m_valid[p] && m_ready[p])
                begin
                    if (exp_q[p].size() == 0)
                    begin
                        $display("Output %0d sent a beat that no packet expected", p);
                        $display("CHECKS FAILED");
                        $fatal(1);
                    end
                    name = name_q[p].pop_front();
                    exp  = exp_q[p].pop_front();
                    check_beat(name, exp, m_beat[p]);
                end
            end
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        int          i;
        int          src_a;
        int          src_b;
        axil_data_t  val;
        void'($urandom(71021));
        s_beat   = '0;
        s_valid  = '0;
        wr       = '0;
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        stall_en = 1'b0;
        resetn   = 1'b0;
        ip_model = RESET_IPS;
        rx_exp   = '0;
        drop_exp = '0;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        @(negedge clk);
        if (s_ready !== '1)
        begin
            $display("Input ports are not ready after reset");
            $display("CHECKS FAILED");
            $fatal(1);
        end
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            read_check("reset ip", REG_IP_BASE + p, ip_model[p]);
            read_check("reset rx", REG_RX_BASE + p, '0);
            read_check("reset drop", REG_DROP_BASE + p, '0);
        end
        read_check("unmapped word 3", 3, '0);

        i = 0;
        while (i < NUM_ROWS)
        begin
            // Partial-strobe write moves port 1 to 192.168.1.32
            if (i == REMAP_ROW)
            begin
                axil_write(REG_IP_BASE + 1, 32'h5555_5520, 4'b0001);
                ip_model[1][7:0] = 8'h20;
                read_check("remap port 1", REG_IP_BASE + 1, ip_model[1]);
            end
            prepare_row(i);
            stall_en = rows[i].stall;
            if (rows[i].par && i + 1 < NUM_ROWS)
            begin
                prepare_row(i + 1);
                stall_en = stall_en | rows[i + 1].stall;
                src_a    = rows[i].src;
                src_b    = rows[i + 1].src;
                fork
                    send_port(src_a);
                    send_port(src_b);
                join
                i = i + 2;
            end
            else
            begin
                send_port(rows[i].src);
                i = i + 1;
            end
            wait_idle();
            stall_en = 1'b0;
        end

        for (int p = 0; p < NUM_PORTS; p++)
        begin
            axil_read(REG_RX_BASE + p, val);
            check_reg("final rx", rx_exp[p], val);
            axil_read(REG_DROP_BASE + p, val);
            check_reg("final drop", drop_exp[p], val);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
design/switch_pkg.sv
design/sync_fifo.sv
design/port_ingress.sv
design/switch_fabric.sv
design/switch_regs.sv
design/packet_switch_top.sv
tb/packet_switch_asserts.sv
tb/packet_switch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module packet_switch_tb --Mdir obj_dir -o packet_switch_sim

./obj_dir/packet_switch_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1
